// File: src.f
+incdir+sim
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/csr_access_decode.sv
hw/csr_trap_regs.sv
hw/csr_int_ctrl.sv
hw/csr_timer.sv
hw/csr_save_regs.sv
hw/csr_top.sv
sim/csr_tb.sv

// File: sim/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

`default_nettype none

// architectural state as software should see it
logic [31:0] m_save [4];
logic [31:0] m_era;
logic [31:0] m_eentry;
logic [31:0] m_ecfg;
logic [31:0] m_badv;
logic [31:0] m_tcfg;
logic [1:0]  m_plv;
logic        m_ie;
logic [1:0]  m_pplv;
logic        m_pie;
logic [5:0]  m_ecode;
logic [8:0]  m_esub;
logic [1:0]  m_sw;
logic        m_ti;  // timer pending

// new bit from val where mask is set, old bit elsewhere, then clip
function automatic logic [31:0] merge_bits(input logic [31:0] old_val, input logic [31:0] mask,
                                           input logic [31:0] val, input logic [31:0] writable);
    return ((val & mask) | (old_val & ~mask)) & writable;
endfunction

function automatic void reset_mirror();
    m_plv   = 2'd0;
    m_ie    = 1'b0;
    m_ecfg  = 32'h0;
    m_sw    = 2'd0;
    m_ti    = 1'b0;
    m_tcfg  = 32'h0;
    m_ecode = 6'h0;
    m_esub  = 9'h0;
endfunction

function automatic void mirror_write(input logic [13:0] num, input logic [31:0] mask,
                                     input logic [31:0] val);
    logic [31:0] w;
    case (num)
        CSR_CRMD: begin
            w     = merge_bits({29'b0, m_ie, m_plv}, mask, val, 32'h7);
            m_plv = w[1:0];
            m_ie  = w[2];
        end
        CSR_PRMD: begin
            w      = merge_bits({29'b0, m_pie, m_pplv}, mask, val, 32'h7);
            m_pplv = w[1:0];
            m_pie  = w[2];
        end
        CSR_ESTAT: begin
            w    = merge_bits({30'b0, m_sw}, mask, val, 32'h3);  // only sw bits writable
            m_sw = w[1:0];
        end
        CSR_ECFG:   m_ecfg    = merge_bits(m_ecfg, mask, val, 32'h0000_1bff);
        CSR_ERA:    m_era     = merge_bits(m_era, mask, val, 32'hffff_ffff);
        CSR_BADV:   m_badv    = merge_bits(m_badv, mask, val, 32'hffff_ffff);
        CSR_EENTRY: m_eentry  = merge_bits(m_eentry, mask, val, 32'hffff_ffc0);
        CSR_SAVE0:  m_save[0] = merge_bits(m_save[0], mask, val, 32'hffff_ffff);
        CSR_SAVE1:  m_save[1] = merge_bits(m_save[1], mask, val, 32'hffff_ffff);
        CSR_SAVE2:  m_save[2] = merge_bits(m_save[2], mask, val, 32'hffff_ffff);
        CSR_SAVE3:  m_save[3] = merge_bits(m_save[3], mask, val, 32'hffff_ffff);
        CSR_TCFG:   m_tcfg    = merge_bits(m_tcfg, mask, val, 32'hffff_ffff);
        CSR_TICLR: begin
            if (mask[0] && val[0]) begin
                m_ti = 1'b0;
            end
        end
        default: ;
    endcase
endfunction

// trap entry as seen by software
function automatic void mirror_trap(input logic [5:0] ec, input logic [8:0] esub,
                                    input logic [31:0] pc, input logic [31:0] va);
    m_pplv  = m_plv;
    m_pie   = m_ie;
    m_plv   = 2'd0;
    m_ie    = 1'b0;
    m_era   = pc;
    m_ecode = ec;
    m_esub  = esub;
    if (ec == ECODE_ADE || ec == ECODE_ALE) begin
        m_badv = (ec == ECODE_ADE && esub == ESUB_ADEF) ? pc : va;
    end
endfunction

function automatic void mirror_ertn();
    m_plv = m_pplv;
    m_ie  = m_pie;
endfunction

function automatic logic [12:0] pending_word();
    logic [12:0] p;
    p       = 13'h0;
    p[1:0]  = m_sw;
    p[11]   = m_ti;
    return p;
endfunction

function automatic logic expected_has_int(input logic [12:0] pend, input logic [12:0] lie,
                                          input logic ie);
    return ie & (|(pend[11:0] & lie[11:0]));
endfunction

// tval is not mirrored, the timer test checks it directly
function automatic logic [31:0] expected_read(input logic [13:0] num);
    case (num)
        CSR_CRMD:   return {28'b0, 1'b1, m_ie, m_plv};  // da reads 1
        CSR_PRMD:   return {29'b0, m_pie, m_pplv};
        CSR_ECFG:   return m_ecfg;
        CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 16'b0} | {19'b0, pending_word()};
        CSR_ERA:    return m_era;
        CSR_BADV:   return m_badv;
        CSR_EENTRY: return m_eentry;
        CSR_SAVE0:  return m_save[0];
        CSR_SAVE1:  return m_save[1];
        CSR_SAVE2:  return m_save[2];
        CSR_SAVE3:  return m_save[3];
        CSR_TCFG:   return m_tcfg;
        default:    return 32'h0;
    endcase
endfunction

`default_nettype wire

`endif

// File: sim/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb;
    import csr_pkg::*;
    import trap_pkg::*;

    localparam int SIG_RVALUE   = 0;
    localparam int SIG_HAS_INT  = 1;
    localparam int SIG_EX_ENTRY = 2;
    localparam int SIG_ERTN_PC  = 3;
    localparam logic [31:0] ALL_ONES = 32'hffff_ffff;

    logic        clk;
    logic        rst;
    logic        csr_re;
    logic [13:0] csr_num;
    csr_data_t   csr_rvalue;
    logic        csr_we;
    csr_wr_t     csr_wr;
    trap_in_t    trap;
    logic        ertn_flush;
    csr_data_t   ex_entry;
    csr_data_t   ertn_pc;
    logic        has_int;

    logic [31:0] rng_state;
    int          chk_sel;
    logic [31:0] chk_exp;
    int          req_cnt  = 0;
    int          done_cnt = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_tests  = 0;
    int          n_failed = 0;
    int          errs_at_start;

    `include "csr_ref_model.svh"

    csr_top #(
        .SAVE_NUM (4)
    ) csr_top_i (
        .clk        (clk),
        .rst        (rst),
        .csr_re     (csr_re),
        .csr_num    (csr_num),
        .csr_rvalue (csr_rvalue),
        .csr_we     (csr_we),
        .csr_wr     (csr_wr),
        .trap       (trap),
        .ertn_flush (ertn_flush),
        .ex_entry   (ex_entry),
        .ertn_pc    (ertn_pc),
        .has_int    (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] observed(input int sel);
        case (sel)
            SIG_HAS_INT:  return {31'b0, has_int};
            SIG_EX_ENTRY: return ex_entry;
            SIG_ERTN_PC:  return ertn_pc;
            default:      return csr_rvalue;
        endcase
    endfunction

    function automatic string sig_name(input int sel);
        case (sel)
            SIG_HAS_INT:  return "has_int";
            SIG_EX_ENTRY: return "ex_entry";
            SIG_ERTN_PC:  return "ertn_pc";
            default:      return "csr_rvalue";
        endcase
    endfunction

    // compare at the falling edge, inputs settled since posedge + 2
    initial begin : compare_proc
        logic [31:0] got;
        forever begin
            @(negedge clk);
            if (req_cnt != done_cnt) begin
                got = observed(chk_sel);
                n_checks++;
                assert (got === chk_exp) else begin
                    $display("MISMATCH t=%0t %s (csr 0x%03h) expected %h got %h",
                             $time, sig_name(chk_sel), csr_num, chk_exp, got);
                    n_errors++;
                end
                done_cnt = req_cnt;
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_sig(input int sel, input logic [31:0] exp);
        int n;
        chk_sel = sel;
        chk_exp = exp;
        req_cnt++;
        n = 0;
        while (done_cnt != req_cnt && n < 4) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (done_cnt != req_cnt) begin
            $display("ERROR t=%0t compare process gave no answer for %s", $time, sig_name(sel));
            n_errors++;
        end
        tick();
    endtask

    task automatic read_expect(input logic [13:0] num, input logic [31:0] exp);
        csr_we  = 1'b0;
        csr_re  = 1'b1;
        csr_num = num;
        expect_sig(SIG_RVALUE, exp);
        csr_re  = 1'b0;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] val);
        csr_re        = 1'b0;
        csr_we        = 1'b1;
        csr_num       = num;
        csr_wr.wmask  = mask;
        csr_wr.wvalue = val;
        mirror_write(num, mask, val);
        tick();
        csr_we = 1'b0;
    endtask

    task automatic raise_trap(input ecode_e ec, input logic [8:0] esub,
                              input logic [31:0] pc, input logic [31:0] va);
        trap.ex       = 1'b1;
        trap.ecode    = ec;
        trap.esubcode = esub;
        trap.pc       = pc;
        trap.vaddr    = va;
        mirror_trap(ec, esub, pc, va);
        tick();
        trap.ex = 1'b0;
    endtask

    task automatic pulse_ertn();
        ertn_flush = 1'b1;
        mirror_ertn();
        tick();
        ertn_flush = 1'b0;
    endtask

    task automatic wait_for(input int sel, input logic [31:0] value, input int limit);
        int   n;
        logic hit;
        hit = 1'b0;
        n   = 0;
        while (!hit && n < limit) begin
            @(negedge clk);
            if (observed(sel) === value) begin
                hit = 1'b1;
            end
            n++;
        end
        if (!hit) begin
            $display("ERROR t=%0t timeout, %s did not reach %h within %0d cycles",
                     $time, sig_name(sel), value, limit);
            n_errors++;
        end
        tick();
    endtask

    function automatic logic [31:0] int_expect();
        return {31'b0, expected_has_int(pending_word(), m_ecfg[12:0], m_ie)};
    endfunction

    task automatic start_test();
        errs_at_start = n_errors;
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (n_errors == errs_at_start) begin
            $display("test %-16s ok", name);
        end else begin
            n_failed++;
            $display("test %-16s FAILED with %0d errors", name, n_errors - errs_at_start);
        end
    endtask

    task automatic masked_access();
        logic [13:0] nums [7];
        int          i;
        int          k;
        start_test();
        nums = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY, CSR_ECFG};
        for (i = 0; i < 7; i++) begin
            write_csr(nums[i], ALL_ONES, next_rand());  // defined start value
            read_expect(nums[i], expected_read(nums[i]));
            for (k = 0; k < 4; k++) begin
                write_csr(nums[i], next_rand(), next_rand());
                read_expect(nums[i], expected_read(nums[i]));
            end
        end
        write_csr(CSR_EENTRY, ALL_ONES, ALL_ONES);
        read_expect(CSR_EENTRY, 32'hffff_ffc0);  // low six bits hardwired
        write_csr(CSR_ECFG, ALL_ONES, ALL_ONES);
        read_expect(CSR_ECFG, 32'h0000_1bff);    // bit 10 reserved
        read_expect(14'h3ff, 32'h0);
        write_csr(CSR_ECFG, ALL_ONES, 32'h0);
        finish_test("masked_access");
    endtask

    task automatic exception_entry();
        logic [31:0] pc;
        start_test();
        write_csr(CSR_CRMD, 32'h7, 32'h7);  // plv 3, ie 1
        read_expect(CSR_CRMD, 32'h0000_000f);
        write_csr(CSR_EENTRY, ALL_ONES, next_rand());
        pc = next_rand();
        raise_trap(ECODE_SYS, 9'h05, pc, next_rand());
        read_expect(CSR_CRMD, 32'h0000_0008);
        read_expect(CSR_PRMD, 32'h0000_0007);
        read_expect(CSR_ERA, pc);
        read_expect(CSR_ESTAT, 32'h014b_0000);  // esub 5, ecode sys
        expect_sig(SIG_EX_ENTRY, expected_read(CSR_EENTRY));
        finish_test("exception_entry");
    endtask

    task automatic badv_capture();
        logic [31:0] pc;
        logic [31:0] va;
        start_test();
        pc = next_rand();
        va = next_rand();
        raise_trap(ECODE_ADE, ESUB_ADEF, pc, va);
        read_expect(CSR_BADV, pc);  // fetch fault keeps the pc
        pc = next_rand();
        va = next_rand();
        raise_trap(ECODE_ALE, 9'h0, pc, va);
        read_expect(CSR_BADV, va);
        pc = next_rand();
        va = next_rand();
        raise_trap(ECODE_ADE, 9'h1, pc, va);
        read_expect(CSR_BADV, va);
        raise_trap(ECODE_SYS, 9'h0, next_rand(), next_rand());
        read_expect(CSR_BADV, va);  // untouched
        read_expect(CSR_ESTAT, expected_read(CSR_ESTAT));
        finish_test("badv_capture");
    endtask

    task automatic trap_return();
        logic [31:0] prmd;
        int          i;
        start_test();
        for (i = 0; i < 4; i++) begin
            prmd = next_rand();
            write_csr(CSR_PRMD, 32'h7, prmd);
            write_csr(CSR_ERA, ALL_ONES, next_rand());
            pulse_ertn();
            read_expect(CSR_CRMD, {28'b0, 1'b1, prmd[2], prmd[1:0]});
            expect_sig(SIG_ERTN_PC, m_era);
        end
        finish_test("trap_return");
    endtask

    task automatic soft_interrupts();
        int i;
        start_test();
        for (i = 0; i < 16; i++) begin
            write_csr(CSR_ESTAT, next_rand(), next_rand());
            write_csr(CSR_ECFG, ALL_ONES, next_rand());
            write_csr(CSR_CRMD, 32'h4, next_rand());  // only ie
            expect_sig(SIG_HAS_INT, int_expect());
            read_expect(CSR_ESTAT, expected_read(CSR_ESTAT));
        end
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        write_csr(CSR_ECFG, ALL_ONES, 32'h0);
        write_csr(CSR_CRMD, 32'h4, 32'h0);
        expect_sig(SIG_HAS_INT, 32'h0);
        finish_test("soft_interrupts");
    endtask

    task automatic timer_expiry();
        start_test();
        write_csr(CSR_ECFG, ALL_ONES, 32'h0000_0800);  // timer line only
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_TCFG, ALL_ONES, {30'd3, 1'b0, 1'b1});  // one-shot, 12 ticks
        read_expect(CSR_TCFG, expected_read(CSR_TCFG));
        wait_for(SIG_HAS_INT, 32'h1, 40);
        m_ti    = 1'b1;
        csr_re  = 1'b1;
        csr_num = CSR_TVAL;
        wait_for(SIG_RVALUE, ALL_ONES, 10);
        repeat (5) tick();
        read_expect(CSR_TVAL, ALL_ONES);  // stopped
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        expect_sig(SIG_HAS_INT, int_expect());
        repeat (20) tick();
        expect_sig(SIG_HAS_INT, int_expect());

        // periodic, 8 ticks per period
        write_csr(CSR_TCFG, ALL_ONES, {30'd2, 1'b1, 1'b1});
        wait_for(SIG_HAS_INT, 32'h1, 30);
        m_ti = 1'b1;
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        expect_sig(SIG_HAS_INT, int_expect());
        wait_for(SIG_HAS_INT, 32'h1, 30);
        write_csr(CSR_TCFG, ALL_ONES, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        expect_sig(SIG_HAS_INT, 32'h0);
        write_csr(CSR_CRMD, 32'h4, 32'h0);
        write_csr(CSR_ECFG, ALL_ONES, 32'h0);
        finish_test("timer_expiry");
    endtask

    initial begin
        rst        = 1'b1;
        csr_re     = 1'b0;
        csr_num    = 14'h0;
        csr_we     = 1'b0;
        csr_wr     = '0;
        trap       = '0;
        ertn_flush = 1'b0;
        rng_state  = 32'hc30e75d5;
        reset_mirror();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        tick();

        masked_access();
        exception_entry();
        badv_capture();
        trap_return();
        soft_interrupts();
        timer_expiry();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
    parameter int SAVE_NUM = 4  // 1 to 4
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          csr_re,
    input  wire logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    output csr_pkg::csr_data_t                 csr_rvalue,
    input  wire logic                          csr_we,
    input  wire csr_pkg::csr_wr_t              csr_wr,
    input  wire trap_pkg::trap_in_t            trap,
    input  wire logic                          ertn_flush,
    output csr_pkg::csr_data_t                 ex_entry,
    output csr_pkg::csr_data_t                 ertn_pc,
    output logic                               has_int
);
    import csr_pkg::*;
    import trap_pkg::*;

    csr_strobe_t                  wr_stb;
    trap_view_t                   trap_v;
    int_view_t                    int_v;
    timer_view_t                  timer_v;
    csr_data_t [SAVE_NUM-1:0]     save_v;
    logic                         crmd_ie;
    logic                         timer_pending;

    csr_access_decode #(
        .SAVE_NUM (SAVE_NUM)
    ) csr_access_decode_i (
        .csr_re     (csr_re),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .trap_v     (trap_v),
        .int_v      (int_v),
        .timer_v    (timer_v),
        .save_v     (save_v),
        .wr_stb     (wr_stb),
        .csr_rvalue (csr_rvalue)
    );

    csr_trap_regs csr_trap_regs_i (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .wr_stb     (wr_stb),
        .trap       (trap),
        .ertn_flush (ertn_flush),
        .trap_v     (trap_v),
        .crmd_ie    (crmd_ie),
        .ex_entry   (ex_entry),
        .ertn_pc    (ertn_pc)
    );

    csr_int_ctrl csr_int_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .csr_wr        (csr_wr),
        .wr_stb        (wr_stb),
        .crmd_ie       (crmd_ie),
        .timer_pending (timer_pending),
        .int_v         (int_v),
        .has_int       (has_int)
    );

    csr_timer csr_timer_i (
        .clk           (clk),
        .rst           (rst),
        .csr_wr        (csr_wr),
        .wr_stb        (wr_stb),
        .timer_v       (timer_v),
        .timer_pending (timer_pending)
    );

    csr_save_regs #(
        .SAVE_NUM (SAVE_NUM)
    ) csr_save_regs_i (
        .clk    (clk),
        .csr_wr (csr_wr),
        .wr_stb (wr_stb),
        .save_v (save_v)
    );

endmodule

`default_nettype wire

// File: hw/csr_save_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_save_regs #(
    parameter int SAVE_NUM = 4
) (
    input  wire logic                        clk,
    input  wire csr_pkg::csr_wr_t            csr_wr,
    input  wire csr_pkg::csr_strobe_t        wr_stb,
    output csr_pkg::csr_data_t [SAVE_NUM-1:0] save_v
);
    import csr_pkg::*;

    // plain scratch words for the trap handler
    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_NUM; i++) begin
            if (wr_stb.save[i]) begin
                save_v[i] <= csr_merge(save_v[i], csr_wr, ALL_WMASK);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire csr_pkg::csr_wr_t     csr_wr,
    input  wire csr_pkg::csr_strobe_t wr_stb,
    output trap_pkg::timer_view_t     timer_v,
    output logic                      timer_pending
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic                   tcfg_en;
    logic                   tcfg_periodic;
    logic [TCFG_INIT_W-1:0] tcfg_initval;
    csr_data_t              tcfg_word;
    csr_data_t              tcfg_next;
    csr_data_t              tval;
    logic                   ticlr_hit;

    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next = csr_merge(tcfg_word, csr_wr, ALL_WMASK);

    assign ticlr_hit = wr_stb.ticlr && csr_wr.wmask[TICLR_CLR_BIT]
                       && csr_wr.wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_stb.tcfg) begin
            tcfg_en       <= tcfg_next[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_next[TCFG_PER_BIT];
            tcfg_initval  <= tcfg_next[CSR_DATA_W-1:CSR_DATA_W-TCFG_INIT_W];
        end
    end

    // countdown, all-ones means stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            tval <= '1;
        end else if (wr_stb.tcfg && tcfg_next[TCFG_EN_BIT]) begin
            tval <= {tcfg_next[CSR_DATA_W-1:CSR_DATA_W-TCFG_INIT_W], 2'b00};  // initval*4
        end else if (tcfg_en && tval != '1) begin
            if (tval == '0 && tcfg_periodic) begin
                tval <= {tcfg_initval, 2'b00};
            end else begin
                tval <= tval - 1'b1;  // one-shot wraps to all-ones
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_pending <= 1'b0;
        end else if (tcfg_en && tval == '0) begin
            timer_pending <= 1'b1;  // expiry wins over ticlr
        end else if (ticlr_hit) begin
            timer_pending <= 1'b0;
        end
    end

    assign timer_v = '{tcfg: tcfg_word, tval: tval, ti: timer_pending};

    a_tval_hold: assert property (@(posedge clk) disable iff (rst)
        (!tcfg_en && !wr_stb.tcfg) |=> $stable(tval));

endmodule

`default_nettype wire

// File: hw/csr_int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_int_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire csr_pkg::csr_wr_t     csr_wr,
    input  wire csr_pkg::csr_strobe_t wr_stb,
    input  wire logic                 crmd_ie,
    input  wire logic                 timer_pending,
    output trap_pkg::int_view_t       int_v,
    output logic                      has_int
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic [INT_W-1:0]   lie;
    logic [IS_SW_W-1:0] sw_is;
    logic [INT_W-1:0]   pending;
    csr_data_t          ecfg_word;
    csr_data_t          ecfg_next;
    csr_data_t          estat_next;

    assign ecfg_word  = {{(CSR_DATA_W-INT_W){1'b0}}, lie};
    assign ecfg_next  = csr_merge(ecfg_word, csr_wr, {{(CSR_DATA_W-INT_W){1'b0}}, LIE_WRITABLE});
    assign estat_next = csr_merge({{(CSR_DATA_W-IS_SW_W){1'b0}}, sw_is}, csr_wr, ESTAT_WMASK);

    always_ff @(posedge clk) begin
        if (rst) begin
            lie   <= '0;
            sw_is <= '0;
        end else begin
            if (wr_stb.ecfg) begin
                lie <= ecfg_next[INT_W-1:0];
            end
            if (wr_stb.estat) begin
                sw_is <= estat_next[IS_SW_W-1:0];  // swi set/clear by software
            end
        end
    end

    // hw lines and ipi are not wired in this core
    always_comb begin
        pending               = '0;
        pending[IS_SW_W-1:0]  = sw_is;
        pending[TIMER_IS_BIT] = timer_pending;
    end

    assign has_int = (|(pending[TIMER_IS_BIT:0] & lie[TIMER_IS_BIT:0])) & crmd_ie;

    assign int_v = '{ecfg: ecfg_word, pending: pending};

endmodule

`default_nettype wire

// File: hw/csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire csr_pkg::csr_wr_t     csr_wr,
    input  wire csr_pkg::csr_strobe_t wr_stb,
    input  wire trap_pkg::trap_in_t   trap,
    input  wire logic                 ertn_flush,
    output trap_pkg::trap_view_t      trap_v,
    output logic                      crmd_ie,
    output csr_pkg::csr_data_t        ex_entry,
    output csr_pkg::csr_data_t        ertn_pc
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic [1:0]  crmd_plv;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    ecode_e      estat_ecode;
    logic [8:0]  estat_esub;
    csr_data_t   era;
    csr_data_t   badv;
    logic [25:0] eentry_va;
    csr_data_t   crmd_word;
    csr_data_t   prmd_word;
    csr_data_t   eentry_word;
    csr_data_t   crmd_next;
    csr_data_t   prmd_next;
    csr_data_t   eentry_next;
    logic        addr_err;

    assign crmd_word   = {28'b0, 1'b1, crmd_ie, crmd_plv};  // da fixed at 1
    assign prmd_word   = {29'b0, prmd_pie, prmd_pplv};
    assign eentry_word = {eentry_va, 6'b0};

    assign crmd_next   = csr_merge(crmd_word, csr_wr, CRMD_WMASK);
    assign prmd_next   = csr_merge(prmd_word, csr_wr, PRMD_WMASK);
    assign eentry_next = csr_merge(eentry_word, csr_wr, EENTRY_WMASK);

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    // trap entry beats ertn, which beats software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
        end else if (trap.ex) begin
            crmd_plv <= 2'd0;  // enter kernel with ints off
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_stb.crmd) begin
            crmd_plv <= crmd_next[1:0];
            crmd_ie  <= crmd_next[2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_ecode <= ECODE_INT;
            estat_esub  <= 9'd0;
        end else if (trap.ex) begin
            estat_ecode <= trap.ecode;
            estat_esub  <= trap.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era       <= trap.pc;
        end else begin
            if (wr_stb.prmd) begin
                prmd_pplv <= prmd_next[1:0];
                prmd_pie  <= prmd_next[2];
            end
            if (wr_stb.era) begin
                era <= csr_merge(era, csr_wr, ALL_WMASK);
            end
        end
        if (trap.ex && addr_err) begin
            // fetch faults report the pc itself
            badv <= (trap.ecode == ECODE_ADE && trap.esubcode == ESUB_ADEF) ?
                    trap.pc : trap.vaddr;
        end else if (!trap.ex && wr_stb.badv) begin
            badv <= csr_merge(badv, csr_wr, ALL_WMASK);
        end
        if (wr_stb.eentry) begin
            eentry_va <= eentry_next[31:6];
        end
    end

    assign trap_v = '{
        crmd:   crmd_word,
        prmd:   prmd_word,
        estat:  {1'b0, estat_esub, estat_ecode, 16'b0},
        era:    era,
        badv:   badv,
        eentry: eentry_word
    };

    assign ex_entry = eentry_word;
    assign ertn_pc  = era;

    // wb stage may not retire an exception and an ertn together
    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (rst)
        !(trap.ex && ertn_flush));

endmodule

`default_nettype wire

// File: hw/csr_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode #(
    parameter int SAVE_NUM = 4
) (
    input  wire logic                                csr_re,
    input  wire logic [csr_pkg::CSR_NUM_W-1:0]       csr_num,
    input  wire logic                                csr_we,
    input  wire trap_pkg::trap_view_t                trap_v,
    input  wire trap_pkg::int_view_t                 int_v,
    input  wire trap_pkg::timer_view_t               timer_v,
    input  wire csr_pkg::csr_data_t [SAVE_NUM-1:0]   save_v,
    output csr_pkg::csr_strobe_t                     wr_stb,
    output csr_pkg::csr_data_t                       csr_rvalue
);
    import csr_pkg::*;
    import trap_pkg::*;

    always_comb begin
        wr_stb     = '0;
        csr_rvalue = '0;  // unknown numbers read zero
        case (csr_num)
            CSR_CRMD: begin
                wr_stb.crmd = csr_we;
                csr_rvalue  = trap_v.crmd;
            end
            CSR_PRMD: begin
                wr_stb.prmd = csr_we;
                csr_rvalue  = trap_v.prmd;
            end
            CSR_ECFG: begin
                wr_stb.ecfg = csr_we;
                csr_rvalue  = int_v.ecfg;
            end
            CSR_ESTAT: begin
                wr_stb.estat = csr_we;
                // cause fields from trap group, is bits from interrupt group
                csr_rvalue = trap_v.estat | {{(CSR_DATA_W-INT_W){1'b0}}, int_v.pending};
            end
            CSR_ERA: begin
                wr_stb.era = csr_we;
                csr_rvalue = trap_v.era;
            end
            CSR_BADV: begin
                wr_stb.badv = csr_we;
                csr_rvalue  = trap_v.badv;
            end
            CSR_EENTRY: begin
                wr_stb.eentry = csr_we;
                csr_rvalue    = trap_v.eentry;
            end
            CSR_TCFG: begin
                wr_stb.tcfg = csr_we;
                csr_rvalue  = timer_v.tcfg;
            end
            CSR_TVAL:  csr_rvalue = timer_v.tval;  // read only
            CSR_TICLR: wr_stb.ticlr = csr_we;      // clr reads back zero
            default: ;
        endcase
        // only implemented save slots decode
        for (int i = 0; i < SAVE_NUM; i++) begin
            if (csr_num == (CSR_NUM_W'(CSR_SAVE0) + CSR_NUM_W'(i))) begin
                wr_stb.save[i] = csr_we;
                csr_rvalue     = save_v[i];
            end
        end
    end

    a_stb_onehot: assert final ($onehot0(wr_stb));
    // core never reads and writes a csr in one access
    a_no_rw_same: assert final (!(csr_re && wr_stb != '0));

endmodule

`default_nettype wire

// File: hw/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // primary exception codes
    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d,
        ECODE_IPE = 6'h0e
    } ecode_e;

    localparam logic [8:0] ESUB_ADEF = 9'h000;  // fetch address error

    // exception report from write-back
    typedef struct packed {
        logic               ex;
        ecode_e             ecode;
        logic [8:0]         esubcode;
        csr_pkg::csr_data_t pc;
        csr_pkg::csr_data_t vaddr;
    } trap_in_t;

    typedef struct packed {
        csr_pkg::csr_data_t crmd;
        csr_pkg::csr_data_t prmd;
        csr_pkg::csr_data_t estat;   // cause fields only
        csr_pkg::csr_data_t era;
        csr_pkg::csr_data_t badv;
        csr_pkg::csr_data_t eentry;
    } trap_view_t;

    typedef struct packed {
        csr_pkg::csr_data_t              ecfg;
        logic [csr_pkg::INT_W-1:0]       pending;
    } int_view_t;

    typedef struct packed {
        csr_pkg::csr_data_t tcfg;
        csr_pkg::csr_data_t tval;
        logic               ti;
    } timer_view_t;

endpackage

`default_nettype wire

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // csr numbers kept in this core
    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef struct packed {
        csr_data_t wmask;
        csr_data_t wvalue;
    } csr_wr_t;

    // one strobe per writable register, tval is read only
    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       ecfg;
        logic       estat;
        logic       era;
        logic       badv;
        logic       eentry;
        logic [3:0] save;
        logic       tcfg;
        logic       ticlr;
    } csr_strobe_t;

    localparam int INT_W        = 13;  // pending / enable word
    localparam int IS_SW_W      = 2;   // software interrupt bits
    localparam int TIMER_IS_BIT = 11;
    localparam int TCFG_INIT_W  = 30;
    localparam int TCFG_EN_BIT  = 0;
    localparam int TCFG_PER_BIT = 1;
    localparam int TICLR_CLR_BIT = 0;

    localparam logic [INT_W-1:0] LIE_WRITABLE = 13'h1bff;  // bit 10 reserved

    localparam csr_data_t CRMD_WMASK   = 32'h0000_0007;  // plv, ie
    localparam csr_data_t PRMD_WMASK   = 32'h0000_0007;  // pplv, pie
    localparam csr_data_t ESTAT_WMASK  = 32'h0000_0003;  // sw is only
    localparam csr_data_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam csr_data_t ALL_WMASK    = 32'hffff_ffff;

    // masked merge, then clip to the writable bits of the register
    function automatic csr_data_t csr_merge(csr_data_t old_val, csr_wr_t wr,
                                            csr_data_t writable);
        return ((wr.wmask & wr.wvalue) | (~wr.wmask & old_val)) & writable;
    endfunction

endpackage

`default_nettype wire
